//--- ddr_bank_config.svh
// bank count, row width, counter width, counter load offset and error counter width
`ifndef DDR_BANK_CONFIG_SVH
`define DDR_BANK_CONFIG_SVH

// number of banks in the device, one bank timer each
`define DDR_NUM_BANKS 4

// row address width carried by ACT and checked on RD/WR
`define DDR_ROW_WIDTH 14

// shared width of both bank counters and of every programmed delay
`define DDR_TIMER_WIDTH 6

// value a bank counter takes on its trigger, so a delay of N is met N-3 cycles later
`define DDR_TIMER_OFFSET 3

// width of the saturating illegal command counter
`define DDR_ERR_COUNT_WIDTH 8

`endif

//--- ddr_bank_pkg.sv
// width typedefs, command opcode enum, and command, timing, bank command and bank status structs
`include "ddr_bank_config.svh"

package ddr_bank_pkg;

    // index of one bank
    typedef logic [$clog2(`DDR_NUM_BANKS)-1:0] bank_id_t;

    // row address as seen on the command bus
    typedef logic [`DDR_ROW_WIDTH-1:0] row_addr_t;

    // counter value or programmed delay in controller clocks
    typedef logic [`DDR_TIMER_WIDTH-1:0] timer_val_t;

    // command opcodes, NOP keeps the zero encoding
    typedef enum logic [2:0] {
        CMD_NOP = 3'd0,
        CMD_ACT = 3'd1,
        CMD_RD  = 3'd2,
        CMD_WR  = 3'd3,
        CMD_PRE = 3'd4
    } cmd_op_e;

    // one command as it arrives with its strobe
    typedef struct packed {
        cmd_op_e   op;
        bank_id_t  bank;
        row_addr_t row;
        logic      auto_pch;
    } ddr_cmd_t;

    // run-time delays, all in controller clocks
    typedef struct packed {
        timer_val_t act_to_rdwr;
        timer_val_t act_to_act;
        timer_val_t act_to_pch;
        timer_val_t rd_to_pch;
        timer_val_t wr_to_pch;
        timer_val_t rd_ap_to_act;
        timer_val_t wr_ap_to_act;
        timer_val_t pch_to_act;
    } bank_timing_t;

    // per-bank pulses from decode, the row only matters with open
    typedef struct packed {
        logic      open;
        logic      close;
        logic      read;
        logic      write;
        row_addr_t row;
    } bank_cmd_t;

    // what a bank timer reports back every cycle
    typedef struct packed {
        logic      is_open;
        row_addr_t open_row;
        logic      rdwr_ready;
        logic      act_ready;
        logic      pch_ready;
    } bank_status_t;

endpackage

//--- ddr_cmd_decode.sv
// command register and per-bank open/close/read/write pulse decoder
`timescale 1ns/1ns
`include "ddr_bank_config.svh"

module ddr_cmd_decode
(
    input  logic                                        ctl_clk,
    input  logic                                        ctl_reset_n,
    input  logic                                        cmd_valid,
    input  ddr_bank_pkg::ddr_cmd_t                      cmd,
    output logic                                        act_valid,
    output ddr_bank_pkg::ddr_cmd_t                      act_cmd,
    output ddr_bank_pkg::bank_cmd_t [`DDR_NUM_BANKS-1:0] bank_cmd
);

    import ddr_bank_pkg::*;

    // opcode hits of the registered command qualified by its strobe
    logic hit_act;
    logic hit_pre;
    logic hit_rd;
    logic hit_wr;
    logic hit_close;

    // registered strobe, one cycle behind cmd_valid
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            act_valid <= 1'b0;
        end
        else
        begin
            act_valid <= cmd_valid;
        end
    end

    // registered command payload
    always_ff @(posedge ctl_clk)
    begin
        act_cmd <= cmd;
    end

    always_comb
    begin
        hit_act = act_valid && (act_cmd.op == CMD_ACT);
        hit_pre = act_valid && (act_cmd.op == CMD_PRE);
        hit_rd  = act_valid && (act_cmd.op == CMD_RD);
        hit_wr  = act_valid && (act_cmd.op == CMD_WR);
        // a read or write with auto-precharge closes the bank in the same pulse
        hit_close = hit_pre || ((hit_rd || hit_wr) && act_cmd.auto_pch);
    end

    // only the addressed bank gets pulses while the row goes to every bank
    always_comb
    begin
        for (int b = 0; b < `DDR_NUM_BANKS; b++)
        begin
            bank_cmd[b].open  = hit_act && (act_cmd.bank == bank_id_t'(b));
            bank_cmd[b].close = hit_close && (act_cmd.bank == bank_id_t'(b));
            bank_cmd[b].read  = hit_rd && (act_cmd.bank == bank_id_t'(b));
            bank_cmd[b].write = hit_wr && (act_cmd.bank == bank_id_t'(b));
            bank_cmd[b].row   = act_cmd.row;
        end
    end

    // an opcode outside the enum would give no pulse and pass the result stage as legal
    a_defined_opcode: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        act_valid |-> (act_cmd.op inside {CMD_NOP, CMD_ACT, CMD_RD, CMD_WR, CMD_PRE})
    );

endmodule

//--- ddr_bank_timer.sv
// per-bank open state, open row, activate and general counters, and the three ready flags
`timescale 1ns/1ns
`include "ddr_bank_config.svh"

module ddr_bank_timer
(
    input  logic                       ctl_clk,
    input  logic                       ctl_reset_n,
    input  ddr_bank_pkg::bank_timing_t timing,
    input  ddr_bank_pkg::bank_cmd_t    bank_cmd,
    output ddr_bank_pkg::bank_status_t status
);

    import ddr_bank_pkg::*;

    // time since the last activate, and since the last read, write or close
    timer_val_t act_cnt;
    timer_val_t gen_cnt;

    // what the last column access and the last close were
    logic doing_read;
    logic doing_ap;
    logic doing_pch;

    logic      is_open;
    row_addr_t open_row;
    logic      rdwr_ready;

    // partial readiness, combined below into act_ready and pch_ready
    logic act_to_act_ok;
    logic act_to_pch_ok;
    logic pch_done;

    // delay that applies to gen_cnt for the current precharge and access type
    timer_val_t pch_delay;

    // a short tRCD must be met right at the activate, the counter is too late for it
    logic short_rcd;

    assign short_rcd = (timing.act_to_rdwr < timer_val_t'(2));

    // activate counter restarts on open and saturates at all ones
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            act_cnt <= '0;
        end
        else if (bank_cmd.open)
        begin
            act_cnt <= timer_val_t'(`DDR_TIMER_OFFSET);
        end
        else if (act_cnt != '1)
        begin
            act_cnt <= act_cnt + 1'b1;
        end
    end

    // general counter restarts on any column access or close
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            gen_cnt <= '0;
        end
        else if (bank_cmd.read || bank_cmd.write || bank_cmd.close)
        begin
            gen_cnt <= timer_val_t'(`DDR_TIMER_OFFSET);
        end
        else if (gen_cnt != '1)
        begin
            gen_cnt <= gen_cnt + 1'b1;
        end
    end

    // access type and precharge type marks, plus the open state and row
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            doing_read <= 1'b0;
            doing_ap   <= 1'b0;
            doing_pch  <= 1'b0;
            is_open    <= 1'b0;
            open_row   <= '0;
        end
        else
        begin
            // write wins if both ever showed up together
            if (bank_cmd.write)
            begin
                doing_read <= 1'b0;
            end
            else if (bank_cmd.read)
            begin
                doing_read <= 1'b1;
            end
            if (bank_cmd.close)
            begin
                doing_ap  <= bank_cmd.read || bank_cmd.write;
                doing_pch <= !(bank_cmd.read || bank_cmd.write);
            end
            else if (bank_cmd.open)
            begin
                doing_ap  <= 1'b0;
                doing_pch <= 1'b0;
            end
            if (bank_cmd.open)
            begin
                is_open  <= 1'b1;
                open_row <= bank_cmd.row;
            end
            else if (bank_cmd.close)
            begin
                is_open <= 1'b0;
            end
        end
    end

    // pick tRP, the auto-precharge recovery or the access-to-precharge delay
    always_comb
    begin
        if (doing_pch)
            pch_delay = timing.pch_to_act;
        else if (doing_ap)
            pch_delay = doing_read ? timing.rd_ap_to_act : timing.wr_ap_to_act;
        else
            pch_delay = doing_read ? timing.rd_to_pch : timing.wr_to_pch;
    end

    // ready flags are registered, so they lag their counters by one clock
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            rdwr_ready    <= 1'b0;
            act_to_act_ok <= 1'b1;
            act_to_pch_ok <= 1'b0;
            pch_done      <= 1'b0;
        end
        else
        begin
            if (bank_cmd.close)
                rdwr_ready <= 1'b0;
            else if (bank_cmd.open && short_rcd)
                rdwr_ready <= 1'b1;
            else
                rdwr_ready <= is_open && (act_cnt >= timing.act_to_rdwr);
            // tRC and tRAS both restart with the activate
            act_to_act_ok <= !bank_cmd.open && (act_cnt >= timing.act_to_act);
            act_to_pch_ok <= !bank_cmd.open && (act_cnt >= timing.act_to_pch);
            pch_done      <= !bank_cmd.close && (gen_cnt >= pch_delay);
        end
    end

    assign status.is_open    = is_open;
    assign status.open_row   = open_row;
    assign status.rdwr_ready = rdwr_ready;
    assign status.act_ready  = act_to_act_ok & pch_done;
    assign status.pch_ready  = act_to_pch_ok & pch_done;

    // decode never sends activate and precharge to one bank at once
    a_no_open_close: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        !(bank_cmd.open && bank_cmd.close)
    );

    // illegal traffic is still executed, so an access to a closed bank is only flagged
    a_access_open_bank: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        (bank_cmd.read || bank_cmd.write) |-> (is_open || bank_cmd.open)
    ) else $warning("read or write reached a closed bank");

endmodule

//--- ddr_cmd_result.sv
// command legality check against bank status, done strobe, error flag and error count
`timescale 1ns/1ns
`include "ddr_bank_config.svh"

module ddr_cmd_result
(
    input  logic                                           ctl_clk,
    input  logic                                           ctl_reset_n,
    input  logic                                           act_valid,
    input  ddr_bank_pkg::ddr_cmd_t                         act_cmd,
    input  ddr_bank_pkg::bank_status_t [`DDR_NUM_BANKS-1:0] status,
    output logic                                           done,
    output logic                                           error,
    output logic [`DDR_ERR_COUNT_WIDTH-1:0]                err_count
);

    import ddr_bank_pkg::*;

    // status of the addressed bank as it was before the command lands
    bank_status_t sel_status;
    logic         legal;
    logic         row_hit;

    assign sel_status = status[act_cmd.bank];
    assign row_hit    = (sel_status.open_row == act_cmd.row);

    // legality table where NOP is always fine
    always_comb
    begin
        case (act_cmd.op)
            CMD_ACT:
                legal = !sel_status.is_open && sel_status.act_ready;
            CMD_RD, CMD_WR:
                legal = sel_status.is_open && row_hit && sel_status.rdwr_ready;
            CMD_PRE:
                legal = sel_status.is_open && sel_status.pch_ready;
            default:
                legal = 1'b1;
        endcase
    end

    // done lands two clocks after cmd_valid with the verdict alongside
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            done  <= 1'b0;
            error <= 1'b0;
        end
        else
        begin
            done  <= act_valid;
            error <= act_valid && !legal;
        end
    end

    // count illegal commands and stick at the top
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            err_count <= '0;
        end
        else if (act_valid && !legal && (err_count != '1))
        begin
            err_count <= err_count + 1'b1;
        end
    end

    // a bank that accepts column commands also reports itself open
    a_ready_bank_open: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        sel_status.rdwr_ready |-> sel_status.is_open
    );

endmodule

//--- ddr_bank_ctrl_top.sv
// top level wiring of command decode, the bank timer array and the result check
`timescale 1ns/1ns
`include "ddr_bank_config.svh"

module ddr_bank_ctrl_top
(
    input  logic                                           ctl_clk,
    input  logic                                           ctl_reset_n,
    input  logic                                           cmd_valid,
    input  ddr_bank_pkg::ddr_cmd_t                         cmd,
    input  ddr_bank_pkg::bank_timing_t                     timing,
    output ddr_bank_pkg::bank_status_t [`DDR_NUM_BANKS-1:0] status,
    output logic                                           done,
    output logic                                           error,
    output logic [`DDR_ERR_COUNT_WIDTH-1:0]                err_count
);

    import ddr_bank_pkg::*;

    // registered command for the result stage
    logic     act_valid;
    ddr_cmd_t act_cmd;

    // pulses to each bank timer
    bank_cmd_t [`DDR_NUM_BANKS-1:0] bank_cmd;

    ddr_cmd_decode u_decode (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .act_valid   (act_valid),
        .act_cmd     (act_cmd),
        .bank_cmd    (bank_cmd)
    );

    // one timer per bank, all sharing the same timing set
    for (genvar b = 0; b < `DDR_NUM_BANKS; b++)
    begin : g_bank
        ddr_bank_timer u_timer (
            .ctl_clk     (ctl_clk),
            .ctl_reset_n (ctl_reset_n),
            .timing      (timing),
            .bank_cmd    (bank_cmd[b]),
            .status      (status[b])
        );
    end

    ddr_cmd_result u_result (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .act_valid   (act_valid),
        .act_cmd     (act_cmd),
        .status      (status),
        .done        (done),
        .error       (error),
        .err_count   (err_count)
    );

endmodule

//--- tb_ddr_bank_ctrl.sv
// testbench for the bank controller with a cycle model of decode, bank timers and legality
`timescale 1ns/1ns
`include "ddr_bank_config.svh"

module tb_ddr_bank_ctrl;

    import ddr_bank_pkg::*;

    // cycles allowed for the last done strobes to come back
    localparam int DRAIN_LIMIT = 20;

    // what the model keeps for one bank to mirror the timer state
    typedef struct packed {
        timer_val_t act_cnt;
        timer_val_t gen_cnt;
        logic       doing_read;
        logic       doing_ap;
        logic       doing_pch;
        logic       is_open;
        row_addr_t  open_row;
        logic       rdwr_ready;
        logic       a2a_ok;
        logic       a2p_ok;
        logic       pch_done;
    } bank_model_t;

    logic                                   ctl_clk;
    logic                                   ctl_reset_n;
    logic                                   cmd_valid;
    ddr_cmd_t                               cmd;
    bank_timing_t                           timing;
    bank_status_t [`DDR_NUM_BANKS-1:0]      status;
    logic                                   done;
    logic                                   error;
    logic [`DDR_ERR_COUNT_WIDTH-1:0]        err_count;

    // model of the decode register and the result stage
    logic                                   m_act_valid;
    ddr_cmd_t                               m_act_cmd;
    logic                                   m_done;
    logic                                   m_error;
    logic [`DDR_ERR_COUNT_WIDTH-1:0]        m_err_count;
    bank_model_t                            m_bank [`DDR_NUM_BANKS];

    // bank that got an activate or an auto-precharge on the last edge or -1 when none
    int m_opened;
    int m_ap_closed;

    int issued;
    int completed;

    ddr_bank_ctrl_top uut (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .timing      (timing),
        .status      (status),
        .done        (done),
        .error       (error),
        .err_count   (err_count)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #50 ctl_clk = ~ctl_clk;
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "wrong value from the DUT");
    endtask

    task automatic stop_on_timeout(input string msg);
        $display("timeout: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "the DUT stopped responding");
    endtask

    function automatic timer_val_t sat_inc(input timer_val_t v);
        return (v == '1) ? v : timer_val_t'(v + 1'b1);
    endfunction

    // status a bank shows with act and pch readiness gated by the precharge-done flag
    function automatic bank_status_t model_status(input int b);
        bank_status_t s;
        s.is_open    = m_bank[b].is_open;
        s.open_row   = m_bank[b].open_row;
        s.rdwr_ready = m_bank[b].rdwr_ready;
        s.act_ready  = m_bank[b].a2a_ok & m_bank[b].pch_done;
        s.pch_ready  = m_bank[b].a2p_ok & m_bank[b].pch_done;
        return s;
    endfunction

    // the general counter delay depends on how the bank was last closed or accessed
    function automatic timer_val_t pick_delay(input bank_model_t m);
        if (m.doing_pch)
            return timing.pch_to_act;
        if (m.doing_ap)
            return m.doing_read ? timing.rd_ap_to_act : timing.wr_ap_to_act;
        return m.doing_read ? timing.rd_to_pch : timing.wr_to_pch;
    endfunction

    function automatic logic cmd_legal(input ddr_cmd_t c, input bank_status_t s);
        case (c.op)
            CMD_ACT:
                return !s.is_open && s.act_ready;
            CMD_RD, CMD_WR:
                return s.is_open && (s.open_row == c.row) && s.rdwr_ready;
            CMD_PRE:
                return s.is_open && s.pch_ready;
            default:
                return 1'b1;
        endcase
    endfunction

    // about four in five commands are picked legal from what the model shows now
    function automatic ddr_cmd_t choose_cmd();
        ddr_cmd_t     c;
        bank_status_t s;
        c.bank     = bank_id_t'($urandom_range(0, `DDR_NUM_BANKS - 1));
        c.row      = row_addr_t'($urandom);
        c.auto_pch = ($urandom_range(0, 3) == 0);
        c.op       = CMD_NOP;
        if ($urandom_range(0, 99) < 80)
        begin
            s = model_status(int'(c.bank));
            if (!s.is_open && s.act_ready)
            begin
                c.op = CMD_ACT;
            end
            else if (s.is_open && s.pch_ready && ($urandom_range(0, 3) == 0))
            begin
                c.op = CMD_PRE;
            end
            else if (s.is_open && s.rdwr_ready)
            begin
                c.op  = ($urandom_range(0, 1) != 0) ? CMD_RD : CMD_WR;
                c.row = s.open_row;
            end
            else if (s.is_open && s.pch_ready)
            begin
                c.op = CMD_PRE;
            end
        end
        else
        begin
            c.op = cmd_op_e'($urandom_range(0, 4));
        end
        return c;
    endfunction

    task automatic reset_model();
        m_act_valid = 1'b0;
        m_act_cmd   = '0;
        m_done      = 1'b0;
        m_error     = 1'b0;
        m_err_count = '0;
        m_opened    = -1;
        m_ap_closed = -1;
        for (int b = 0; b < `DDR_NUM_BANKS; b++)
        begin
            m_bank[b] = '0;
            // tRC is taken as met out of reset
            m_bank[b].a2a_ok = 1'b1;
        end
    endtask

    // advance the model across one rising edge, using the inputs held before it
    task automatic update_model();
        bank_model_t cur;
        bank_model_t nxt;
        logic        hit;
        logic        op;
        logic        cl;
        logic        rd;
        logic        wr;
        // the result stage judges the command on the status before it lands
        m_done  = m_act_valid;
        m_error = m_act_valid && !cmd_legal(m_act_cmd, model_status(int'(m_act_cmd.bank)));
        if (m_error && (m_err_count != '1))
            m_err_count = m_err_count + 1'b1;
        m_opened    = -1;
        m_ap_closed = -1;
        for (int b = 0; b < `DDR_NUM_BANKS; b++)
        begin
            cur = m_bank[b];
            nxt = cur;
            hit = m_act_valid && (m_act_cmd.bank == bank_id_t'(b));
            op  = hit && (m_act_cmd.op == CMD_ACT);
            rd  = hit && (m_act_cmd.op == CMD_RD);
            wr  = hit && (m_act_cmd.op == CMD_WR);
            cl  = hit && ((m_act_cmd.op == CMD_PRE) || ((rd || wr) && m_act_cmd.auto_pch));
            nxt.act_cnt = op ? timer_val_t'(`DDR_TIMER_OFFSET) : sat_inc(cur.act_cnt);
            nxt.gen_cnt = (rd || wr || cl) ? timer_val_t'(`DDR_TIMER_OFFSET)
                                           : sat_inc(cur.gen_cnt);
            if (wr)
                nxt.doing_read = 1'b0;
            else if (rd)
                nxt.doing_read = 1'b1;
            if (cl)
            begin
                nxt.doing_ap  = rd || wr;
                nxt.doing_pch = !(rd || wr);
            end
            else if (op)
            begin
                nxt.doing_ap  = 1'b0;
                nxt.doing_pch = 1'b0;
            end
            if (op)
            begin
                nxt.is_open  = 1'b1;
                nxt.open_row = m_act_cmd.row;
                m_opened     = b;
            end
            else if (cl)
            begin
                nxt.is_open = 1'b0;
            end
            if (cl && (rd || wr))
                m_ap_closed = b;
            if (cl)
                nxt.rdwr_ready = 1'b0;
            else if (op && (timing.act_to_rdwr < timer_val_t'(2)))
                nxt.rdwr_ready = 1'b1;
            else
                nxt.rdwr_ready = cur.is_open && (cur.act_cnt >= timing.act_to_rdwr);
            nxt.a2a_ok   = !op && (cur.act_cnt >= timing.act_to_act);
            nxt.a2p_ok   = !op && (cur.act_cnt >= timing.act_to_pch);
            nxt.pch_done = !cl && (cur.gen_cnt >= pick_delay(cur));
            m_bank[b] = nxt;
        end
        m_act_valid = cmd_valid;
        m_act_cmd   = cmd;
    endtask

    task automatic check_outputs();
        bank_status_t exp;
        // a short tRCD makes the bank accessible right after the activate pulse
        if ((m_opened >= 0) && (timing.act_to_rdwr < timer_val_t'(2)))
        begin
            assert (status[m_opened].rdwr_ready === 1'b1)
            else report_mismatch($sformatf("bank %0d not ready right after ACT", m_opened));
        end
        if (m_ap_closed >= 0)
        begin
            assert (status[m_ap_closed].is_open === 1'b0)
            else report_mismatch($sformatf("bank %0d still open after auto-precharge",
                                           m_ap_closed));
        end
        for (int b = 0; b < `DDR_NUM_BANKS; b++)
        begin
            exp = model_status(b);
            assert (status[b] === exp)
            else report_mismatch($sformatf("bank %0d status %h, expected %h",
                                           b, status[b], exp));
        end
        assert (done === m_done)
        else report_mismatch($sformatf("done is %b, expected %b", done, m_done));
        assert (error === m_error)
        else report_mismatch($sformatf("error is %b, expected %b", error, m_error));
        assert (err_count === m_err_count)
        else report_mismatch($sformatf("err_count is %0d, expected %0d",
                                       err_count, m_err_count));
        if (done === 1'b1)
            completed++;
    endtask

    // the model follows the edge and outputs are checked once they have settled
    task automatic step_cycle();
        @(posedge ctl_clk);
        update_model();
        #10;
        check_outputs();
    endtask

    task automatic apply_reset(input logic short_rcd);
        ctl_reset_n = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        timing.act_to_rdwr  = short_rcd ? timer_val_t'($urandom_range(0, 1))
                                        : timer_val_t'($urandom_range(2, 12));
        timing.act_to_act   = timer_val_t'($urandom_range(0, 12));
        timing.act_to_pch   = timer_val_t'($urandom_range(0, 12));
        timing.rd_to_pch    = timer_val_t'($urandom_range(0, 12));
        timing.wr_to_pch    = timer_val_t'($urandom_range(0, 12));
        timing.rd_ap_to_act = timer_val_t'($urandom_range(0, 12));
        timing.wr_ap_to_act = timer_val_t'($urandom_range(0, 12));
        timing.pch_to_act   = timer_val_t'($urandom_range(0, 12));
        repeat (5) @(posedge ctl_clk);
        #10;
        ctl_reset_n = 1'b1;
        reset_model();
        issued    = 0;
        completed = 0;
        for (int b = 0; b < `DDR_NUM_BANKS; b++)
        begin
            assert (status[b].is_open === 1'b0)
            else report_mismatch($sformatf("bank %0d open after reset", b));
        end
        assert ((done === 1'b0) && (err_count === '0))
        else report_mismatch("done or err_count not clear after reset");
        check_outputs();
    endtask

    task automatic drain_commands();
        int waited;
        cmd_valid = 1'b0;
        waited    = 0;
        while (completed != issued)
        begin
            if (waited == DRAIN_LIMIT)
                stop_on_timeout($sformatf("only %0d of %0d commands reported done",
                                          completed, issued));
            step_cycle();
            waited++;
        end
    endtask

    task automatic run_commands(input int count);
        int gap;
        for (int i = 0; i < count; i++)
        begin
            gap       = $urandom_range(0, 3);
            cmd_valid = 1'b0;
            repeat (gap) step_cycle();
            cmd       = choose_cmd();
            cmd_valid = 1'b1;
            issued++;
            step_cycle();
        end
        drain_commands();
    endtask

    initial
    begin
        ctl_reset_n = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        timing      = '0;
        void'($urandom(32'h1e26));
        apply_reset(1'b0);
        run_commands(2000);
        // second pass with tRCD short enough to take the immediate path
        apply_reset(1'b1);
        run_commands(2000);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
ddr_bank_pkg.sv
ddr_cmd_decode.sv
ddr_bank_timer.sv
ddr_cmd_result.sv
ddr_bank_ctrl_top.sv
tb_ddr_bank_ctrl.sv

//--- Bender.yml
package:
  name: ddr_bank_ctrl

sources:
  - include_dirs:
      - .
    files:
      - ddr_bank_pkg.sv
      - ddr_cmd_decode.sv
      - ddr_bank_timer.sv
      - ddr_cmd_result.sv
      - ddr_bank_ctrl_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ddr_bank_ctrl.sv
